// ==== rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data and address width of the core.
`define XLEN 32

// integer register file geometry, REG_AW must cover REG_COUNT.
`define REG_COUNT 32
`define REG_AW 5

`endif

// ==== rvIsaPkg.sv ====
`include "rv_defines.svh"

package rvIsaPkg;

	// major opcodes of the RV32I subset that decode knows about.
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcodeE;

	typedef enum logic [2:0] {
		BR_EQ  = 3'b000,
		BR_NE  = 3'b001,
		BR_LT  = 3'b100,
		BR_GE  = 3'b101,
		BR_LTU = 3'b110,
		BR_GEU = 3'b111
	} branchCondE; // same encoding as funct3 of a branch.

	// raw fields of the fetched word, imm already sign extended.
	typedef struct packed {
		logic [`REG_AW-1:0] rd;
		logic [`REG_AW-1:0] rs1;
		logic [`REG_AW-1:0] rs2;
		logic [2:0]         funct3;
		logic [6:0]         funct7;
		logic [`XLEN-1:0]   imm;
		opcodeE             opcode;
	} instrFieldsT;

endpackage

// ==== rvCtrlPkg.sv ====
`include "rv_defines.svh"

package rvCtrlPkg;

	typedef enum logic [4:0] {
		ALU_ADD   = 5'd0,
		ALU_SUB   = 5'd1,
		ALU_SLL   = 5'd2,
		ALU_SLT   = 5'd3,
		ALU_SLTU  = 5'd4,
		ALU_XOR   = 5'd5,
		ALU_SRL   = 5'd6,
		ALU_SRA   = 5'd7,
		ALU_OR    = 5'd8,
		ALU_AND   = 5'd9,
		ALU_PASSB = 5'd10 // operand b straight through, used by lui.
	} aluOpE;

	typedef enum logic [1:0] {OPA_REG, OPA_PC, OPA_ZERO} opASelE;
	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wbSelE;
	typedef enum logic [1:0] {FWD_REGFILE, FWD_WRITEBACK, FWD_MEMORY} fwdSelE;

	// bit 1 is the branch redirect and bit 0 the jump redirect.
	typedef enum logic [1:0] {PC_NEXT = 2'b00, PC_JUMP = 2'b01, PC_BRANCH = 2'b10} pcSelE;

	typedef struct packed {
		logic   regWrite;
		opASelE opASel;
		logic   opBSelImm;
		logic   memAccess;
		logic   memWrite;
		wbSelE  wbSel;
		aluOpE  aluOp;
		logic   branch;
		logic   jump;
	} ctrlT;

	typedef struct packed {
		logic               we;
		logic [`REG_AW-1:0] rd;
		logic [`XLEN-1:0]   data;
	} writeBackT;

endpackage

// ==== instrDecoder.sv ====
`timescale 1ns/10ps
`include "rv_defines.svh"

module instrDecoder import rvIsaPkg::*, rvCtrlPkg::*; (
	input  logic [`XLEN-1:0] instr,
	output instrFieldsT      fields,
	output ctrlT             ctrl
);

	opcodeE           opcode;
	logic [`XLEN-1:0] immI;
	logic [`XLEN-1:0] immS;
	logic [`XLEN-1:0] immB;
	logic [`XLEN-1:0] immU;
	logic [`XLEN-1:0] immJ;
	logic [`XLEN-1:0] imm;

	// funct3 picks the operation, alt is funct7 bit 5.
	function automatic aluOpE aluFromFunct(input logic [2:0] f3, input logic alt,
			input logic isOp);
		aluOpE op;
		case (f3)
			3'b000: op = (alt && isOp) ? ALU_SUB : ALU_ADD; // addi has no subtract form.
			3'b001: op = ALU_SLL;
			3'b010: op = ALU_SLT;
			3'b011: op = ALU_SLTU;
			3'b100: op = ALU_XOR;
			3'b101: op = alt ? ALU_SRA : ALU_SRL;
			3'b110: op = ALU_OR;
			3'b111: op = ALU_AND;
		endcase
		return op;
	endfunction

	assign opcode = opcodeE'(instr[6:0]);

	assign immI = {{(`XLEN-12){instr[31]}}, instr[31:20]};
	assign immS = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immU = {instr[31:12], 12'b0};
	assign immJ = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21],
		1'b0};

	always_comb begin
		case (opcode)
			OPC_LOAD, OPC_OP_IMM, OPC_JALR: imm = immI;
			OPC_STORE:                      imm = immS;
			OPC_BRANCH:                     imm = immB;
			OPC_LUI, OPC_AUIPC:             imm = immU;
			OPC_JAL:                        imm = immJ;
			default:                        imm = '0; // register ops carry no immediate.
		endcase
	end

	always_comb begin
		fields.rd     = instr[11:7];
		fields.rs1    = instr[19:15];
		fields.rs2    = instr[24:20];
		fields.funct3 = instr[14:12];
		fields.funct7 = instr[31:25];
		fields.imm    = imm;
		fields.opcode = opcode;
	end

	always_comb begin
		ctrl = '0;
		case (opcode)
			OPC_LUI: begin
				ctrl.regWrite  = 1'b1;
				ctrl.opBSelImm = 1'b1;
				ctrl.aluOp     = ALU_PASSB;
			end
			OPC_AUIPC: begin
				ctrl.regWrite  = 1'b1;
				ctrl.opASel    = OPA_PC;
				ctrl.opBSelImm = 1'b1;
			end
			OPC_JAL, OPC_JALR: begin
				ctrl.regWrite  = 1'b1;
				ctrl.opBSelImm = (opcode == OPC_JALR);
				ctrl.wbSel     = WB_PC4; // link register gets the return address.
				ctrl.jump      = 1'b1;
			end
			OPC_BRANCH: ctrl.branch = 1'b1;
			OPC_LOAD: begin
				ctrl.regWrite  = 1'b1;
				ctrl.opBSelImm = 1'b1;
				ctrl.memAccess = 1'b1;
				ctrl.wbSel     = WB_MEM;
			end
			OPC_STORE: begin
				ctrl.opBSelImm = 1'b1;
				ctrl.memAccess = 1'b1;
				ctrl.memWrite  = 1'b1;
			end
			OPC_OP_IMM: begin
				ctrl.regWrite  = 1'b1;
				ctrl.opBSelImm = 1'b1;
				ctrl.aluOp     = aluFromFunct(instr[14:12], instr[30], 1'b0);
			end
			OPC_OP: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = aluFromFunct(instr[14:12], instr[30], 1'b1);
			end
			default: ctrl = '0;
		endcase
	end

	// the branch unit would redirect twice if both were set.
	always_comb begin
		assert final (!(ctrl.branch && ctrl.jump))
			else $error("decoder set branch and jump together for %h", instr);
	end

endmodule

// ==== regFile.sv ====
`timescale 1ns/10ps
`include "rv_defines.svh"

module regFile import rvCtrlPkg::*; (
	input  logic               clk,
	input  logic               rstN,
	input  writeBackT          wb,
	input  logic [`REG_AW-1:0] rs1Addr,
	input  logic [`REG_AW-1:0] rs2Addr,
	output logic [`XLEN-1:0]   rs1Data,
	output logic [`XLEN-1:0]   rs2Data
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.we && (wb.rd != '0)) begin
			regs[wb.rd] <= wb.data; // x0 is never written, so it stays at its reset value.
		end
	end

	// no bypass here. a same cycle read of wb goes through forwarding.
	assign rs1Data = regs[rs1Addr];
	assign rs2Data = regs[rs2Addr];

	x0ReadsZero: assert property (@(posedge clk) disable iff (!rstN)
		((rs1Addr != '0) || (rs1Data == '0)) && ((rs2Addr != '0) || (rs2Data == '0)))
		else $error("register x0 read back a nonzero value");

endmodule

// ==== operandRead.sv ====
`timescale 1ns/10ps
`include "rv_defines.svh"

module operandRead import rvCtrlPkg::*; (
	input  logic               clk,
	input  logic               rstN,
	input  logic [`REG_AW-1:0] rs1Addr,
	input  logic [`REG_AW-1:0] rs2Addr,
	input  writeBackT          wb,
	input  fwdSelE             fwd1,
	input  fwdSelE             fwd2,
	input  logic [`XLEN-1:0]   aluOutM,
	output logic [`XLEN-1:0]   rs1Val,
	output logic [`XLEN-1:0]   rs2Val
);

	logic [`XLEN-1:0] rs1Reg;
	logic [`XLEN-1:0] rs2Reg;

	function automatic logic [`XLEN-1:0] pickOperand(input fwdSelE sel,
			input logic [`XLEN-1:0] regVal, input logic [`XLEN-1:0] wbVal,
			input logic [`XLEN-1:0] memVal);
		logic [`XLEN-1:0] val;
		case (sel)
			FWD_REGFILE:   val = regVal;
			FWD_WRITEBACK: val = wbVal;
			FWD_MEMORY:    val = memVal;
			default:       val = '0;
		endcase
		return val;
	endfunction

	regFile mRegFile (
		.clk     (clk),
		.rstN    (rstN),
		.wb      (wb),
		.rs1Addr (rs1Addr),
		.rs2Addr (rs2Addr),
		.rs1Data (rs1Reg),
		.rs2Data (rs2Reg)
	);

	assign rs1Val = pickOperand(fwd1, rs1Reg, wb.data, aluOutM);
	assign rs2Val = pickOperand(fwd2, rs2Reg, wb.data, aluOutM);

	// the hazard unit drives only the three defined codes.
	fwdSelValid: assert property (@(posedge clk) disable iff (!rstN)
		(fwd1 inside {FWD_REGFILE, FWD_WRITEBACK, FWD_MEMORY}) &&
		(fwd2 inside {FWD_REGFILE, FWD_WRITEBACK, FWD_MEMORY}))
		else $error("undefined forward select %b %b", fwd1, fwd2);

endmodule

// ==== branchUnit.sv ====
`timescale 1ns/10ps
`include "rv_defines.svh"

module branchUnit import rvIsaPkg::*, rvCtrlPkg::*; (
	input  logic [`XLEN-1:0] pcPlus4,
	input  logic [`XLEN-1:0] imm,
	input  logic [`XLEN-1:0] rs1Val,
	input  logic [`XLEN-1:0] rs2Val,
	input  branchCondE       cond,
	input  logic             branch,
	input  logic             jump,
	input  logic             jalr,
	output logic [`XLEN-1:0] branchTarget,
	output logic [`XLEN-1:0] jumpTarget,
	output pcSelE            pcSel
);

	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] jalrSum;
	logic             taken;

	assign pc = pcPlus4 - `XLEN'(4);

	// branches and jal share the pc relative adder.
	assign branchTarget = pc + imm;
	assign jalrSum      = rs1Val + imm;
	assign jumpTarget   = jalr ? {jalrSum[`XLEN-1:1], 1'b0} : branchTarget;

	always_comb begin
		case (cond)
			BR_EQ:   taken = (rs1Val == rs2Val);
			BR_NE:   taken = (rs1Val != rs2Val);
			BR_LT:   taken = ($signed(rs1Val) < $signed(rs2Val));
			BR_GE:   taken = ($signed(rs1Val) >= $signed(rs2Val));
			BR_LTU:  taken = (rs1Val < rs2Val);
			BR_GEU:  taken = (rs1Val >= rs2Val);
			default: taken = 1'b0; // funct3 010 and 011 are no branch.
		endcase
	end

	always_comb begin
		if (jump) begin
			pcSel = PC_JUMP;
		end else if (branch && taken) begin
			pcSel = PC_BRANCH;
		end else begin
			pcSel = PC_NEXT;
		end
	end

	always_comb begin
		assert final (branch || (pcSel != PC_BRANCH))
			else $error("branch redirect without a branch instruction");
	end

endmodule

// ==== decodeStage.sv ====
`timescale 1ns/10ps
`include "rv_defines.svh"

module decodeStage import rvIsaPkg::*, rvCtrlPkg::*; (
	input  logic             clk,
	input  logic             rstN,
	input  logic [`XLEN-1:0] instr,
	input  logic [`XLEN-1:0] pcPlus4,
	input  fwdSelE           fwd1, // forward selects from the hazard unit.
	input  fwdSelE           fwd2,
	input  writeBackT        wb,
	input  logic [`XLEN-1:0] aluOutM,
	output instrFieldsT      fields,
	output ctrlT             ctrl,
	output logic [`XLEN-1:0] rs1Val,
	output logic [`XLEN-1:0] rs2Val,
	output logic [`XLEN-1:0] branchTarget,
	output logic [`XLEN-1:0] jumpTarget,
	output pcSelE            pcSel
);

	instrDecoder mDecoder (
		.instr  (instr),
		.fields (fields),
		.ctrl   (ctrl)
	);

	// register read runs next to the decoder on the raw address fields.
	operandRead mOperandRead (
		.clk     (clk),
		.rstN    (rstN),
		.rs1Addr (fields.rs1),
		.rs2Addr (fields.rs2),
		.wb      (wb),
		.fwd1    (fwd1),
		.fwd2    (fwd2),
		.aluOutM (aluOutM),
		.rs1Val  (rs1Val),
		.rs2Val  (rs2Val)
	);

	branchUnit mBranchUnit (
		.pcPlus4      (pcPlus4),
		.imm          (fields.imm),
		.rs1Val       (rs1Val), // compares see the forwarded operands.
		.rs2Val       (rs2Val),
		.cond         (branchCondE'(fields.funct3)),
		.branch       (ctrl.branch),
		.jump         (ctrl.jump),
		.jalr         (fields.opcode == OPC_JALR),
		.branchTarget (branchTarget),
		.jumpTarget   (jumpTarget),
		.pcSel        (pcSel)
	);

endmodule

// ==== tbDecodeStage.sv ====
`timescale 1ns/10ps
`include "rv_defines.svh"

module tbDecodeStage import rvIsaPkg::*, rvCtrlPkg::*; ();

	logic             clk;
	logic             rstN;
	logic [`XLEN-1:0] instr;
	logic [`XLEN-1:0] pcPlus4;
	logic [`XLEN-1:0] aluOutM;
	fwdSelE           fwd1;
	fwdSelE           fwd2;
	writeBackT        wb;
	instrFieldsT      fields;
	ctrlT             ctrl;
	logic [`XLEN-1:0] rs1Val;
	logic [`XLEN-1:0] rs2Val;
	logic [`XLEN-1:0] branchTarget;
	logic [`XLEN-1:0] jumpTarget;
	pcSelE            pcSel;

	logic [`XLEN-1:0] seed;
	logic [`XLEN-1:0] regModel [`REG_COUNT]; // what each register should hold.

	decodeStage u_dut (
		.clk          (clk),
		.rstN         (rstN),
		.instr        (instr),
		.pcPlus4      (pcPlus4),
		.fwd1         (fwd1),
		.fwd2         (fwd2),
		.wb           (wb),
		.aluOutM      (aluOutM),
		.fields       (fields),
		.ctrl         (ctrl),
		.rs1Val       (rs1Val),
		.rs2Val       (rs2Val),
		.branchTarget (branchTarget),
		.jumpTarget   (jumpTarget),
		.pcSel        (pcSel)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] nextRandom();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// instruction encoders for the RV32I formats.
	function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input opcodeE opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input opcodeE opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
	endfunction

	function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] encU(input logic [31:0] imm, input logic [4:0] rd,
			input opcodeE opc);
		return {imm[31:12], rd, opc};
	endfunction

	function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	function automatic ctrlT makeCtrl(input logic regWrite, input opASelE opASel,
			input logic opBSelImm, input logic memAccess, input logic memWrite,
			input wbSelE wbSel, input aluOpE aluOp, input logic branch, input logic jump);
		ctrlT c;
		c.regWrite  = regWrite;
		c.opASel    = opASel;
		c.opBSelImm = opBSelImm;
		c.memAccess = memAccess;
		c.memWrite  = memWrite;
		c.wbSel     = wbSel;
		c.aluOp     = aluOp;
		c.branch    = branch;
		c.jump      = jump;
		return c;
	endfunction

	function automatic logic condHolds(input branchCondE c, input logic [31:0] a,
			input logic [31:0] b);
		case (c)
			BR_EQ:   return a == b;
			BR_NE:   return a != b;
			BR_LT:   return $signed(a) < $signed(b);
			BR_GE:   return $signed(a) >= $signed(b);
			BR_LTU:  return a < b;
			default: return a >= b; // the unsigned greater or equal case.
		endcase
	endfunction

	task automatic stopOnError(input string line);
		$display("%s", line);
		$display("Checks failed");
		$fatal(1, "simulation stopped at the first failing check");
	endtask

	task automatic waitClk(input logic level);
		int n;
		n = 0;
		while (clk !== level) begin
			if (n >= 200) begin
				stopOnError("timed out waiting for the clock, it stopped toggling");
			end
			#1;
			n++;
		end
	endtask

	// inputs change shortly after the rising edge and are sampled at the falling one.
	task automatic nextDrive();
		waitClk(1'b0);
		waitClk(1'b1);
		#5;
	endtask

	task automatic settle();
		waitClk(1'b0);
	endtask

	task automatic checkFields(input instrFieldsT got, input instrFieldsT exp, input string what);
		if (got !== exp) begin
			stopOnError($sformatf("error at %0t ns: %s fields got %h expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic checkCtrl(input ctrlT got, input ctrlT exp, input string what);
		if (got !== exp) begin
			stopOnError($sformatf("error at %0t ns: %s control got %h expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic checkWord(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			stopOnError($sformatf("error at %0t ns: %s got %h expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic checkPcSel(input pcSelE got, input pcSelE exp, input string what);
		if (got !== exp) begin
			stopOnError($sformatf("error at %0t ns: %s pcSel got %s expected %s",
				$time, what, got.name(), exp.name()));
		end
	endtask

	task automatic resetDut();
		rstN = 1'b0;
		repeat (4) nextDrive();
		rstN = 1'b1;
	endtask

	task automatic testRegFile();
		logic [31:0] v;
		for (int r = 0; r < 32; r++) begin
			nextDrive();
			instr = encR(7'h00, 5'(r), 5'(r), 3'b000, 5'd3, OPC_OP);
			settle();
			checkWord(rs1Val, 32'h0, $sformatf("x%0d after reset", r));
		end
		for (int r = 0; r < 32; r++) begin
			v = nextRandom();
			nextDrive();
			wb = '{we: 1'b1, rd: 5'(r), data: v};
			instr = encR(7'h00, 5'd0, 5'(r), 3'b000, 5'd1, OPC_OP);
			settle();
			checkWord(rs1Val, regModel[r], $sformatf("x%0d in its write cycle", r));
			nextDrive();
			wb.we = 1'b0;
			if (r != 0) begin
				regModel[r] = v; // x0 ignores the write.
			end
			settle();
			checkWord(rs1Val, regModel[r], $sformatf("x%0d after its write", r));
		end
		for (int r = 0; r < 32; r++) begin
			nextDrive();
			instr = encR(7'h00, 5'(31 - r), 5'(r), 3'b000, 5'd1, OPC_OP);
			settle();
			checkWord(rs1Val, regModel[r], $sformatf("x%0d on port 1", r));
			checkWord(rs2Val, regModel[31 - r], $sformatf("x%0d on port 2", 31 - r));
		end
	endtask

	task automatic testForwarding();
		fwdSelE      sels [3];
		logic [31:0] wbData;
		logic [31:0] memData;
		logic [31:0] exp1;
		logic [31:0] exp2;
		sels = '{FWD_REGFILE, FWD_WRITEBACK, FWD_MEMORY};
		for (int k = 0; k < 3; k++) begin
			wbData  = nextRandom();
			memData = nextRandom();
			nextDrive();
			instr   = encR(7'h00, 5'd9, 5'd5, 3'b000, 5'd1, OPC_OP);
			wb      = '{we: 1'b1, rd: 5'd5, data: wbData};
			aluOutM = memData;
			fwd1    = sels[k];
			fwd2    = sels[k];
			case (sels[k])
				FWD_REGFILE: begin
					exp1 = regModel[5];
					exp2 = regModel[9];
				end
				FWD_WRITEBACK: begin
					exp1 = wbData;
					exp2 = wbData;
				end
				default: begin
					exp1 = memData;
					exp2 = memData;
				end
			endcase
			settle();
			checkWord(rs1Val, exp1, $sformatf("rs1 forwarded from %s", sels[k].name()));
			checkWord(rs2Val, exp2, $sformatf("rs2 forwarded from %s", sels[k].name()));
			nextDrive();
			wb.we       = 1'b0;
			fwd1        = FWD_REGFILE;
			fwd2        = FWD_REGFILE;
			regModel[5] = wbData;
			settle();
			checkWord(rs1Val, regModel[5], "x5 after the forwarded write");
		end
	endtask

	task automatic decodeCase(input logic [31:0] ins, input logic [31:0] imm, input ctrlT expCtrl,
			input string what);
		instrFieldsT exp;
		exp.rd     = ins[11:7];
		exp.rs1    = ins[19:15];
		exp.rs2    = ins[24:20];
		exp.funct3 = ins[14:12];
		exp.funct7 = ins[31:25];
		exp.imm    = imm;
		exp.opcode = opcodeE'(ins[6:0]);
		nextDrive();
		instr = ins;
		settle();
		checkFields(fields, exp, what);
		checkCtrl(ctrl, expCtrl, what);
	endtask

	task automatic testDecoding();
		decodeCase(encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OPC_OP), 32'h0,
			makeCtrl(1'b1, OPA_REG, 1'b0, 1'b0, 1'b0, WB_ALU, ALU_ADD, 1'b0, 1'b0), "add");
		decodeCase(encR(7'h20, 5'd6, 5'd5, 3'b000, 5'd4, OPC_OP), 32'h0,
			makeCtrl(1'b1, OPA_REG, 1'b0, 1'b0, 1'b0, WB_ALU, ALU_SUB, 1'b0, 1'b0), "sub");
		decodeCase(encR(7'h20, 5'd9, 5'd8, 3'b101, 5'd7, OPC_OP), 32'h0,
			makeCtrl(1'b1, OPA_REG, 1'b0, 1'b0, 1'b0, WB_ALU, ALU_SRA, 1'b0, 1'b0), "sra");
		decodeCase(encI(12'hffb, 5'd2, 3'b000, 5'd1, OPC_OP_IMM), 32'hffff_fffb,
			makeCtrl(1'b1, OPA_REG, 1'b1, 1'b0, 1'b0, WB_ALU, ALU_ADD, 1'b0, 1'b0), "addi");
		decodeCase(encI(12'h407, 5'd4, 3'b101, 5'd3, OPC_OP_IMM), 32'h0000_0407,
			makeCtrl(1'b1, OPA_REG, 1'b1, 1'b0, 1'b0, WB_ALU, ALU_SRA, 1'b0, 1'b0), "srai");
		decodeCase(encI(12'hfff, 5'd6, 3'b011, 5'd5, OPC_OP_IMM), 32'hffff_ffff,
			makeCtrl(1'b1, OPA_REG, 1'b1, 1'b0, 1'b0, WB_ALU, ALU_SLTU, 1'b0, 1'b0), "sltiu");
		decodeCase(encI(12'hff0, 5'd11, 3'b010, 5'd10, OPC_LOAD), 32'hffff_fff0,
			makeCtrl(1'b1, OPA_REG, 1'b1, 1'b1, 1'b0, WB_MEM, ALU_ADD, 1'b0, 1'b0), "lw");
		decodeCase(encS(12'h7ff, 5'd12, 5'd13, 3'b010), 32'h0000_07ff,
			makeCtrl(1'b0, OPA_REG, 1'b1, 1'b1, 1'b1, WB_ALU, ALU_ADD, 1'b0, 1'b0), "sw");
		decodeCase(encB(13'h1ff8, 5'd2, 5'd1, 3'b000), 32'hffff_fff8,
			makeCtrl(1'b0, OPA_REG, 1'b0, 1'b0, 1'b0, WB_ALU, ALU_ADD, 1'b1, 1'b0), "beq");
		decodeCase(encU(32'hffff_f000, 5'd14, OPC_LUI), 32'hffff_f000,
			makeCtrl(1'b1, OPA_REG, 1'b1, 1'b0, 1'b0, WB_ALU, ALU_PASSB, 1'b0, 1'b0), "lui");
		decodeCase(encU(32'h1234_5000, 5'd15, OPC_AUIPC), 32'h1234_5000,
			makeCtrl(1'b1, OPA_PC, 1'b1, 1'b0, 1'b0, WB_ALU, ALU_ADD, 1'b0, 1'b0), "auipc");
		decodeCase(encJ(21'h1f_f800, 5'd1), 32'hffff_f800,
			makeCtrl(1'b1, OPA_REG, 1'b0, 1'b0, 1'b0, WB_PC4, ALU_ADD, 1'b0, 1'b1), "jal");
		decodeCase(encI(12'h00c, 5'd2, 3'b000, 5'd1, OPC_JALR), 32'h0000_000c,
			makeCtrl(1'b1, OPA_REG, 1'b1, 1'b0, 1'b0, WB_PC4, ALU_ADD, 1'b0, 1'b1), "jalr");
		decodeCase(32'hfe00_007f, 32'h0, '0, "unknown opcode");
		decodeCase(32'h0, 32'h0, '0, "all zero word");
		checkPcSel(pcSel, PC_NEXT, "all zero word");
	endtask

	task automatic testBranches();
		branchCondE  conds [6];
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		logic [31:0] imm;
		logic [12:0] off;
		pcSelE       expSel;
		conds = '{BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU};
		for (int c = 0; c < 6; c++) begin
			for (int n = 0; n < 6; n++) begin
				a   = nextRandom();
				// one equal pair and one pair of opposite sign per condition.
				b   = (n == 0) ? a : (n == 1) ? ~a : nextRandom();
				r   = nextRandom();
				off = {r[12:1], 1'b0};
				imm = {{19{off[12]}}, off};
				nextDrive();
				instr   = encB(off, 5'd7, 5'd6, conds[c]);
				pcPlus4 = nextRandom() & 32'hffff_fffc;
				fwd1    = FWD_MEMORY;
				aluOutM = a;
				fwd2    = FWD_WRITEBACK;
				wb      = '{we: 1'b0, rd: 5'd0, data: b};
				expSel  = condHolds(conds[c], a, b) ? PC_BRANCH : PC_NEXT;
				settle();
				checkWord(rs1Val, a, "branch operand 1");
				checkWord(rs2Val, b, "branch operand 2");
				checkPcSel(pcSel, expSel, conds[c].name());
				checkWord(branchTarget, pcPlus4 - 32'd4 + imm, "branch target");
			end
		end
	endtask

	task automatic testJumps();
		logic [31:0] r;
		logic [31:0] a;
		logic [31:0] imm;
		logic [20:0] offJ;
		logic [31:0] plain [4];
		for (int n = 0; n < 4; n++) begin
			r    = nextRandom();
			offJ = {r[20:1], 1'b0};
			imm  = {{11{offJ[20]}}, offJ};
			nextDrive();
			instr   = encJ(offJ, 5'd1);
			pcPlus4 = {r[31:2] ^ 30'h1555_5555, 2'b00};
			settle();
			checkWord(jumpTarget, pcPlus4 - 32'd4 + imm, "jal target");
			checkPcSel(pcSel, PC_JUMP, "jal");
			r   = nextRandom();
			a   = nextRandom();
			imm = {{20{r[11]}}, r[11:0]};
			nextDrive();
			instr   = encI(r[11:0], 5'd2, 3'b000, 5'd1, OPC_JALR);
			fwd1    = FWD_MEMORY;
			aluOutM = a;
			settle();
			checkWord(jumpTarget, (a + imm) & 32'hffff_fffe, "jalr target"); // bit 0 dropped.
			checkPcSel(pcSel, PC_JUMP, "jalr");
		end
		plain = '{encI(12'h001, 5'd1, 3'b000, 5'd1, OPC_OP_IMM),
			encI(12'h004, 5'd2, 3'b010, 5'd3, OPC_LOAD),
			encS(12'h008, 5'd4, 5'd5, 3'b010),
			encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OPC_OP)};
		for (int n = 0; n < 4; n++) begin
			nextDrive();
			instr = plain[n];
			settle();
			checkPcSel(pcSel, PC_NEXT, $sformatf("non control word %h", plain[n]));
		end
	endtask

	initial begin
		seed    = 32'hf013_b136;
		rstN    = 1'b0;
		instr   = '0;
		pcPlus4 = '0;
		aluOutM = '0;
		fwd1    = FWD_REGFILE;
		fwd2    = FWD_REGFILE;
		wb      = '0;
		for (int i = 0; i < `REG_COUNT; i++) begin
			regModel[i] = '0;
		end
		resetDut();
		testRegFile();
		testForwarding();
		testDecoding();
		testBranches();
		testJumps();
		$display("All checks passed");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+.
rvIsaPkg.sv
rvCtrlPkg.sv
instrDecoder.sv
regFile.sv
operandRead.sv
branchUnit.sv
decodeStage.sv
tbDecodeStage.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbDecodeStage -f files.f -o simDecodeStage

out=$(./obj_dir/simDecodeStage 2>&1) || true
printf '%s\n' "$out"

# the run passes only if the testbench reported success.
printf '%s\n' "$out" | grep -q "All checks passed"
